//--- compile.f
+incdir+rtl
rtl/rv_pkg.sv
rtl/rvDecoder.sv
rtl/rvRegFile.sv
rtl/rvAlu.sv
rtl/rvCore.sv
sim/rvCore_checker.sv
sim/rvCore_tb.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal -j 0
TOP       = rvCore_tb
FILELIST  = compile.f
OBJDIR    = obj_dir
PASSTEXT  = Finished with no errors

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

# the simulation output is searched for the exact pass line
run: compile
	@out="$$(./$(OBJDIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASSTEXT)"

clean:
	rm -rf $(OBJDIR)

//--- sim/rvCore_tb.sv
// testbench for the RV32I core with clock, reset, bus memory with random
// busy delays, instruction encoders, directed tests and reporting
`timescale 1ns/100ps
`include "rv_defines.svh"

module rvCore_tb;
   import rv_pkg::*;

   localparam int memWords = 2048;
   // x31 holds this base and results go upward from it
   localparam logic [`RV_XLEN-1:0] resultBase = 32'h0000_1000;
   localparam logic [6:0] codeLoad  = 7'b0000011;
   localparam logic [6:0] codeImm   = 7'b0010011;
   localparam logic [6:0] codeAuipc = 7'b0010111;
   localparam logic [6:0] codeLui   = 7'b0110111;
   localparam logic [6:0] codeJalr  = 7'b1100111;

   logic    clk = 1'b0;
   logic    reset = 1'b0;
   memReq_t memReq;
   memRsp_t memRsp = '0;

   logic [`RV_XLEN-1:0] mem [memWords];
   logic [31:0]         seed = 32'hf4a59820;
   int                  readCount = 0;
   int                  writeCount = 0;
   time                 deadline = 0;
   int                  resultIdx = 0;
   int                  errorCount = 0;
   int                  testCount = 0;
   int                  failedTests = 0;

   // program, expected stores, preloaded data and observed stores
   logic [31:0] prog [$];
   logic [31:0] expAddrQ [$];
   logic [31:0] expDataQ [$];
   logic [31:0] preAddrQ [$];
   logic [31:0] preDataQ [$];
   logic [31:0] storeAddrQ [$];
   logic [31:0] storeDataQ [$];

   rvCore DUT (
      .clk    (clk),
      .reset  (reset),
      .memReq (memReq),
      .memRsp (memRsp)
   );

   initial begin
      forever #5 clk = ~clk;
   end

   function automatic logic [31:0] lcg();
      seed = seed * 32'd1664525 + 32'd1013904223;
      return seed;
   endfunction

   // extra busy cycles from 0 to 3
   function automatic int busyLength();
      logic [31:0] r;
      r = lcg();
      return int'(r[17:16]);
   endfunction

   // bus memory where a counter of 1 means data is ready in the next cycle
   always @(negedge clk) begin
      if (memReq.rstrb) begin
         memRsp.rdata <= mem[memReq.addr[12:2]];
         readCount = busyLength() + 1;
      end else if (readCount != 0) begin
         readCount--;
      end
      if (memReq.wmask == 4'b1111) begin
         mem[memReq.addr[12:2]] = memReq.wdata;
         storeAddrQ.push_back(memReq.addr);
         storeDataQ.push_back(memReq.wdata);
         writeCount = busyLength() + 1;
      end else if (writeCount != 0) begin
         writeCount--;
      end
      memRsp.rbusy <= (readCount != 0);
      memRsp.wbusy <= (writeCount != 0);
   end

   // watchdog whose deadline is moved forward by each test
   initial begin
      forever begin
         @(posedge clk);
         if (reset && ($time > deadline)) begin
            $display("Timeout: the core did not complete its test program in time");
            $display("Finished with errors");
            $finish;
         end
      end
   end

   // RV32I encoders with arguments in the field order of the format
   function automatic logic [31:0] encR(input logic [6:0] f7, input logic [4:0] rs2,
                                        input logic [4:0] rs1, input logic [2:0] f3,
                                        input logic [4:0] rd);
      return {f7, rs2, rs1, f3, rd, 7'b0110011};
   endfunction

   function automatic logic [31:0] encI(input logic [11:0] imm, input logic [4:0] rs1,
                                        input logic [2:0] f3, input logic [4:0] rd,
                                        input logic [6:0] opc);
      return {imm, rs1, f3, rd, opc};
   endfunction

   // sw only since the width field is always word
   function automatic logic [31:0] encS(input logic [11:0] imm, input logic [4:0] rs2,
                                        input logic [4:0] rs1);
      return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
   endfunction

   function automatic logic [31:0] encB(input logic [12:0] imm, input logic [4:0] rs2,
                                        input logic [4:0] rs1, input logic [2:0] f3);
      return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
   endfunction

   function automatic logic [31:0] encU(input logic [19:0] imm, input logic [4:0] rd,
                                        input logic [6:0] opc);
      return {imm, rd, opc};
   endfunction

   function automatic logic [31:0] encJ(input logic [20:0] imm, input logic [4:0] rd);
      return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
   endfunction

   task automatic emit(input logic [31:0] instr);
      prog.push_back(instr);
   endtask

   task automatic emitAddi(input logic [4:0] rd, input logic [4:0] rs1,
                           input logic [11:0] imm);
      emit(encI(imm, rs1, 3'b000, rd, codeImm));
   endtask

   // lui plus addi with the upper part rounded for the sign of the low 12 bits
   task automatic emitConst(input logic [4:0] rd, input logic [31:0] value);
      logic [31:0] upper;
      upper = value + 32'h800;
      emit(encU(upper[31:12], rd, codeLui));
      emitAddi(rd, rd, value[11:0]);
   endtask

   task automatic expectStore(input logic [31:0] addr, input logic [31:0] data);
      expAddrQ.push_back(addr);
      expDataQ.push_back(data);
   endtask

   task automatic emitResult(input logic [4:0] rs, input logic [31:0] value);
      emit(encS(12'(4 * resultIdx), rs, 5'd31));
      expectStore(resultBase + 32'(4 * resultIdx), value);
      resultIdx++;
   endtask

   task automatic beginProgram();
      prog.delete();
      expAddrQ.delete();
      expDataQ.delete();
      preAddrQ.delete();
      preDataQ.delete();
      resultIdx = 0;
      emit(encU(20'h00001, 5'd31, codeLui));
   endtask

   task automatic checkWord(input logic [`RV_XLEN-1:0] got,
                            input logic [`RV_XLEN-1:0] expected, input int idx);
      if (got !== expected) begin
         $display("Fail at time %0t: store %0d wrote %h, expected %h",
                  $time, idx, got, expected);
         errorCount++;
      end
   endtask

   task automatic checkAddr(input logic [`RV_XLEN-1:0] got,
                            input logic [`RV_XLEN-1:0] expected, input int idx);
      if (got !== expected) begin
         $display("Fail at time %0t: store %0d went to address %h, expected %h",
                  $time, idx, got, expected);
         errorCount++;
      end
   endtask

   // load memory, reset the core, wait for all stores and compare them
   task automatic runProgram(input string name);
      int startErrors;
      startErrors = errorCount;
      // jump-to-self ends every program
      emit(encJ(21'd0, 5'd0));
      @(negedge clk);
      reset = 1'b0;
      for (int i = 0; i < memWords; i++) begin
         mem[i] = (32'(i) * 32'h9e37_79b9) ^ 32'h0f0f_0000;
      end
      foreach (prog[i]) begin
         mem[i] = prog[i];
      end
      foreach (preAddrQ[i]) begin
         mem[preAddrQ[i][12:2]] = preDataQ[i];
      end
      deadline = $time + 80 + prog.size() * 450;
      repeat (8) @(negedge clk);
      storeAddrQ.delete();
      storeDataQ.delete();
      reset = 1'b1;
      while (storeAddrQ.size() < expAddrQ.size()) begin
         @(posedge clk);
      end
      foreach (expAddrQ[i]) begin
         checkAddr(storeAddrQ[i], expAddrQ[i], i);
         checkWord(storeDataQ[i], expDataQ[i], i);
      end
      testCount++;
      if (errorCount != startErrors) begin
         failedTests++;
         $display("%s: failed with %0d errors", name, errorCount - startErrors);
      end else begin
         $display("%s: passed, %0d stores checked", name, expAddrQ.size());
      end
   endtask

   // op 0 add, 1 sub, 2 slt, 3 sltu, 4 xor, 5 or, 6 and
   function automatic logic [2:0] aluFunct3(input int op);
      case (op)
         0, 1: return 3'b000;
         2: return 3'b010;
         3: return 3'b011;
         4: return 3'b100;
         5: return 3'b110;
         default: return 3'b111;
      endcase
   endfunction

   function automatic logic [31:0] aluExpect(input int op, input logic [31:0] a,
                                             input logic [31:0] b);
      case (op)
         0: return a + b;
         1: return a - b;
         2: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
         3: return (a < b) ? 32'd1 : 32'd0;
         4: return a ^ b;
         5: return a | b;
         default: return a & b;
      endcase
   endfunction

   task automatic testAluOps();
      logic [31:0] a;
      logic [31:0] b;
      logic [31:0] draw;
      logic [31:0] immVal;
      beginProgram();
      for (int iter = 0; iter < 4; iter++) begin
         // first round has a sign-bit pair for the compares
         a = (iter == 0) ? 32'h8000_0000 : lcg();
         b = (iter == 0) ? 32'h0000_0001 : lcg();
         draw = lcg();
         immVal = {{20{draw[11]}}, draw[11:0]};
         emitConst(5'd1, a);
         emitConst(5'd2, b);
         for (int op = 0; op < 7; op++) begin
            emit(encR((op == 1) ? 7'h20 : 7'h00, 5'd2, 5'd1, aluFunct3(op), 5'd3));
            emitResult(5'd3, aluExpect(op, a, b));
            // no immediate form of sub
            if (op != 1) begin
               emit(encI(draw[11:0], 5'd1, aluFunct3(op), 5'd4, codeImm));
               emitResult(5'd4, aluExpect(op, a, immVal));
            end
         end
      end
      runProgram("alu operations");
   endtask

   task automatic testShifts();
      logic [31:0] value;
      logic [31:0] draw;
      logic [31:0] expected;
      logic [4:0]  amt;
      logic [6:0]  f7;
      logic [2:0]  f3;
      beginProgram();
      for (int iter = 0; iter < 4; iter++) begin
         // second round is negative so that sra and srl differ
         value = (iter == 1) ? (lcg() | 32'h8000_0000) : lcg();
         draw = lcg();
         amt = (iter == 0) ? 5'd0 : (iter == 1) ? 5'd31 : draw[4:0];
         emitConst(5'd1, value);
         // upper bits of rs2 must be ignored
         emitConst(5'd2, {draw[31:5], amt});
         for (int kind = 0; kind < 3; kind++) begin
            f3 = (kind == 0) ? 3'b001 : 3'b101;
            f7 = (kind == 2) ? 7'h20 : 7'h00;
            case (kind)
               0: expected = value << amt;
               1: expected = value >> amt;
               default: expected = $signed(value) >>> amt;
            endcase
            emit(encR(f7, 5'd2, 5'd1, f3, 5'd3));
            emitResult(5'd3, expected);
            emit(encI({f7, amt}, 5'd1, f3, 5'd4, codeImm));
            emitResult(5'd4, expected);
         end
      end
      runProgram("shifts");
   endtask

   function automatic logic branchTaken(input logic [2:0] f3, input logic [31:0] a,
                                        input logic [31:0] b);
      case (f3)
         3'b000: return a == b;
         3'b001: return a != b;
         3'b100: return $signed(a) < $signed(b);
         3'b101: return $signed(a) >= $signed(b);
         3'b110: return a < b;
         default: return a >= b;
      endcase
   endfunction

   task automatic testBranches();
      logic [31:0] a;
      logic [31:0] b;
      logic [2:0]  f3;
      beginProgram();
      for (int p = 0; p < 5; p++) begin
         case (p)
            0: begin
               a = 32'd5;
               b = 32'd5;
            end
            1: begin
               a = 32'hffff_fffd;
               b = 32'd2;
            end
            2: begin
               a = 32'd2;
               b = 32'hffff_fffd;
            end
            3: begin
               a = 32'd1;
               b = 32'd2;
            end
            default: begin
               a = 32'h8000_0000;
               b = 32'h7fff_ffff;
            end
         endcase
         emitConst(5'd1, a);
         emitConst(5'd2, b);
         for (int br = 0; br < 6; br++) begin
            f3 = (br < 2) ? 3'(br) : 3'(br + 2);
            // marker is 1 when taken and 2 when the branch falls through
            emitAddi(5'd5, 5'd0, 12'd1);
            emit(encB(13'd8, 5'd2, 5'd1, f3));
            emitAddi(5'd5, 5'd0, 12'd2);
            emitResult(5'd5, branchTaken(f3, a, b) ? 32'd1 : 32'd2);
         end
      end
      runProgram("branches");
   endtask

   task automatic testJumpsAndUpper();
      logic [31:0] here;
      logic [31:0] draw;
      beginProgram();
      emitAddi(5'd7, 5'd0, 12'd1);
      here = 32'(prog.size() * 4);
      emit(encJ(21'd8, 5'd6));
      emitAddi(5'd7, 5'd0, 12'd2);
      emitResult(5'd6, here + 32'd4);
      emitResult(5'd7, 32'd1);
      // auipc x8, 0 then jalr to x8 + 13 which lands on x8 + 12 with the lsb cleared
      here = 32'(prog.size() * 4);
      emit(encU(20'h0, 5'd8, codeAuipc));
      emit(encI(12'd13, 5'd8, 3'b000, 5'd9, codeJalr));
      emitAddi(5'd7, 5'd0, 12'd3);
      emitResult(5'd9, here + 32'd8);
      emitResult(5'd8, here);
      emitResult(5'd7, 32'd1);
      draw = lcg();
      emit(encU(draw[31:12], 5'd10, codeLui));
      emitResult(5'd10, {draw[31:12], 12'h000});
      draw = lcg();
      here = 32'(prog.size() * 4);
      emit(encU(draw[31:12], 5'd11, codeAuipc));
      emitResult(5'd11, here + {draw[31:12], 12'h000});
      runProgram("jumps and upper immediates");
   endtask

   task automatic testMemRoundTrip();
      logic [31:0] vals [4];
      logic [31:0] preWord;
      beginProgram();
      // x12 = 0x1400 for the stores and x15 = 0x1500 for the loads
      emitAddi(5'd12, 5'd31, 12'h400);
      emitAddi(5'd15, 5'd31, 12'h500);
      for (int i = 0; i < 4; i++) begin
         vals[i] = lcg();
         emitConst(5'd1, vals[i]);
         emit(encS(12'(4 * i), 5'd1, 5'd12));
         expectStore(32'h1400 + 32'(4 * i), vals[i]);
      end
      // read back in reverse order through a negative offset
      for (int i = 3; i >= 0; i--) begin
         emit(encI(12'hf00 + 12'(4 * i), 5'd15, 3'b010, 5'd13, codeLoad));
         emitResult(5'd13, vals[i]);
      end
      preWord = lcg();
      preAddrQ.push_back(32'h1600);
      preDataQ.push_back(preWord);
      emit(encI(12'h600, 5'd31, 3'b010, 5'd14, codeLoad));
      emitResult(5'd14, preWord);
      runProgram("memory round trip");
   endtask

   task automatic testRegZero();
      beginProgram();
      emitConst(5'd1, 32'h1234_5678);
      emitAddi(5'd0, 5'd0, 12'd123);
      emit(encU(20'habcde, 5'd0, codeLui));
      emit(encR(7'h00, 5'd1, 5'd1, 3'b000, 5'd0));
      emitResult(5'd0, 32'd0);
      // loaded and linked values for x0 are dropped as well
      preAddrQ.push_back(32'h1700);
      preDataQ.push_back(32'hdead_beef);
      emit(encI(12'h700, 5'd31, 3'b010, 5'd0, codeLoad));
      emitResult(5'd0, 32'd0);
      emit(encJ(21'd4, 5'd0));
      emitResult(5'd0, 32'd0);
      runProgram("register zero");
   endtask

   initial begin
      int unsigned assertFails;
      testAluOps();
      testShifts();
      testBranches();
      testJumpsAndUpper();
      testMemRoundTrip();
      testRegZero();
      assertFails = DUT.uChecker.violations;
      $display("%0d tests run, %0d failed, %0d value errors, %0d assertion failures",
               testCount, failedTests, errorCount, assertFails);
      if ((errorCount == 0) && (assertFails == 0)) begin
         $display("Finished with no errors");
      end else begin
         $display("Finished with errors");
      end
      $finish;
   end

endmodule

//--- sim/rvCore_checker.sv
// bus and controller assertions for the RV32I core bound into rvCore
`timescale 1ns/100ps

module rvCore_checker (
   input logic               clk,
   input logic               reset,
   input rv_pkg::memReq_t    memReq,
   input rv_pkg::memRsp_t    memRsp,
   input rv_pkg::ctrlState_t state
);
   import rv_pkg::*;

   // number of failed assertions
   int unsigned violations = 0;

   // a cycle either reads or writes but never both
   assert property (@(posedge clk) disable iff (!reset)
      !(memReq.rstrb && (memReq.wmask != 4'b0000)))
   else begin
      violations++;
      $error("read strobe and write mask active in the same cycle");
   end

   // only whole words are written
   assert property (@(posedge clk) disable iff (!reset)
      (memReq.wmask == 4'b0000) || (memReq.wmask == 4'b1111))
   else begin
      violations++;
      $error("partial write mask %b", memReq.wmask);
   end

   assert property (@(posedge clk) disable iff (!reset)
      (memReq.wmask != 4'b0000) |-> (memReq.addr[1:0] == 2'b00))
   else begin
      violations++;
      $error("store to unaligned address %h", memReq.addr);
   end

   // instruction word is only taken once rbusy drops
   assert property (@(posedge clk) disable iff (!reset)
      ((state == waitInstr) && memRsp.rbusy) |=> (state == waitInstr))
   else begin
      violations++;
      $error("controller left waitInstr while rbusy was high");
   end

endmodule

bind rvCore rvCore_checker uChecker (
   .clk    (clk),
   .reset  (reset),
   .memReq (memReq),
   .memRsp (memRsp),
   .state  (state)
);

//--- rtl/rvCore.sv
// top level of the multi-cycle RV32I core
// controller FSM, PC, address selection and write-back mux
`timescale 1ns/100ps
`include "rv_defines.svh"

module rvCore #(
   parameter logic [`RV_XLEN-1:0] resetAddr = `RV_RESET_ADDR
) (
   input  logic            clk,
   input  logic            reset,
   output rv_pkg::memReq_t memReq,
   input  rv_pkg::memRsp_t memRsp
);
   import rv_pkg::*;

   ctrlState_t          state;
   logic [`RV_XLEN-1:0] pc;
   // latched instruction word
   logic [`RV_XLEN-1:0] instrWord;
   decodedInstr_t       decoded;

   logic [`RV_XLEN-1:0] rs1Data;
   logic [`RV_XLEN-1:0] rs2Data;
   logic [`RV_XLEN-1:0] aluIn2;
   logic [`RV_XLEN-1:0] aluResult;
   logic [`RV_XLEN-1:0] aluSum;
   logic                aluPredicate;
   logic                aluBusy;
   logic                aluStart;

   logic [`RV_XLEN-1:0] pcPlus4;
   logic [`RV_XLEN-1:0] pcPlusImm;
   logic [`RV_XLEN-1:0] lsAddr;
   logic [`RV_XLEN-1:0] wbData;
   logic                writeBack;
   logic                instrAccept;
   logic                needToWait;
   logic                jumpToImm;

   rvDecoder uDecoder (
      .instrWord (instrWord),
      .decoded   (decoded)
   );

   // operand indices come straight off the bus so they are read
   // in the same cycle the instruction is latched
   rvRegFile uRegFile (
      .clk     (clk),
      .readEn  (instrAccept),
      .rs1Idx  (memRsp.rdata[19:15]),
      .rs2Idx  (memRsp.rdata[24:20]),
      .rs1Data (rs1Data),
      .rs2Data (rs2Data),
      .writeEn (writeBack),
      .rdIdx   (decoded.rd),
      .rdData  (wbData)
   );

   rvAlu uAlu (
      .clk       (clk),
      .reset     (reset),
      .decoded   (decoded),
      .in1       (rs1Data),
      .in2       (aluIn2),
      .start     (aluStart),
      .result    (aluResult),
      .sum       (aluSum),
      .predicate (aluPredicate),
      .busy      (aluBusy)
   );

   assign aluIn2 = decoded.usesRs2Operand ? rs2Data : decoded.immI;

   // instruction word arrives in the first waitInstr cycle without rbusy
   assign instrAccept = (state == waitInstr) && !memRsp.rbusy;

   assign pcPlus4 = pc + `RV_XLEN'd4;
   // jal, auipc and branch targets share one adder
   assign pcPlusImm = pc + ((decoded.opcode == opJal)   ? decoded.immJ :
                            (decoded.opcode == opAuipc) ? decoded.immU :
                                                          decoded.immB);
   // loads use immI and stores use immS
   assign lsAddr = rs1Data + ((decoded.opcode == opStore) ? decoded.immS :
                                                            decoded.immI);

   assign jumpToImm  = (decoded.opcode == opJal) ||
                       ((decoded.opcode == opBranch) && aluPredicate);
   assign needToWait = (decoded.opcode == opLoad) || (decoded.opcode == opStore) ||
                       decoded.isShift;
   assign aluStart   = (state == execute) && decoded.isShift;

   // bus address is the pc during fetch and the data address otherwise
   always_comb begin
      memReq.addr  = ((state == fetchInstr) || (state == waitInstr)) ? pc : lsAddr;
      memReq.wdata = rs2Data;
      // only whole aligned words are stored
      memReq.wmask = {4{(state == execute) && (decoded.opcode == opStore)}};
      memReq.rstrb = (state == fetchInstr) ||
                     ((state == execute) && (decoded.opcode == opLoad));
   end

   // write-back may repeat in waitAluOrMem and the last write carries the final value
   assign writeBack = decoded.writesRd && ((state == execute) || (state == waitAluOrMem));

   always_comb begin
      if (decoded.isAlu) begin
         wbData = aluResult;
      end else begin
         case (decoded.opcode)
            opLui:        wbData = decoded.immU;
            opAuipc:      wbData = pcPlusImm;
            // link address from pc which still holds the jump's own address
            opJal, opJalr: wbData = pcPlus4;
            opLoad:       wbData = memRsp.rdata;
            default:      wbData = '0;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (instrAccept) begin
         instrWord <= memRsp.rdata;
      end
   end

   // controller
   always_ff @(posedge clk) begin
      if (!reset) begin
         // leave reset through the wait state so a pending write drains
         state <= waitAluOrMem;
         pc    <= resetAddr;
      end else begin
         case (state)
            fetchInstr: begin
               state <= waitInstr;
            end
            waitInstr: begin
               if (!memRsp.rbusy) begin
                  state <= execute;
               end
            end
            execute: begin
               // jalr target has its lsb cleared
               if (decoded.opcode == opJalr) begin
                  pc <= {aluSum[`RV_XLEN-1:1], 1'b0};
               end else if (jumpToImm) begin
                  pc <= pcPlusImm;
               end else begin
                  pc <= pcPlus4;
               end
               state <= needToWait ? waitAluOrMem : fetchInstr;
            end
            default: begin
               if (!aluBusy && !memRsp.rbusy && !memRsp.wbusy) begin
                  state <= fetchInstr;
               end
            end
         endcase
      end
   end

endmodule

//--- rtl/rvAlu.sv
// ALU with adder, subtract based compares, logic ops and branch predicate
// plus a serial shifter that moves one bit per cycle
`timescale 1ns/100ps
`include "rv_defines.svh"

module rvAlu (
   input  logic                  clk,
   input  logic                  reset,
   input  rv_pkg::decodedInstr_t decoded,
   input  logic [`RV_XLEN-1:0]   in1,
   input  logic [`RV_XLEN-1:0]   in2,
   input  logic                  start,
   output logic [`RV_XLEN-1:0]   result,
   output logic [`RV_XLEN-1:0]   sum,
   output logic                  predicate,
   output logic                  busy
);

   // one extra bit holds the borrow
   logic [`RV_XLEN:0]       minus;
   logic                    lt;
   logic                    ltu;
   logic                    eq;
   logic [`RV_XLEN-1:0]     shiftReg;
   logic [`RV_SHAMT_W-1:0]  shamt;

   // shared by add, addi and the jalr target
   assign sum = in1 + in2;

   // a single subtract gives sub, equal and both less-than flavours
   assign minus = {1'b0, in1} - {1'b0, in2};
   assign ltu   = minus[`RV_XLEN];
   // with differing signs in1 is smaller exactly when it is negative
   assign lt    = (in1[`RV_XLEN-1] ^ in2[`RV_XLEN-1]) ? in1[`RV_XLEN-1] : ltu;
   assign eq    = (minus[`RV_XLEN-1:0] == '0);

   always_comb begin
      case (decoded.funct3)
         // addi has bit 30 inside its immediate, so bit 5 must qualify sub
         3'b000: result = (decoded.altFunct && decoded.regOperand) ?
                          minus[`RV_XLEN-1:0] : sum;
         3'b010: result = {{(`RV_XLEN-1){1'b0}}, lt};
         3'b011: result = {{(`RV_XLEN-1){1'b0}}, ltu};
         3'b100: result = in1 ^ in2;
         3'b110: result = in1 | in2;
         3'b111: result = in1 & in2;
         // shifter output for 001 and 101
         default: result = shiftReg;
      endcase
   end

   always_comb begin
      case (decoded.funct3)
         3'b000: predicate = eq;
         3'b001: predicate = !eq;
         3'b100: predicate = lt;
         3'b101: predicate = !lt;
         3'b110: predicate = ltu;
         3'b111: predicate = !ltu;
         default: predicate = 1'b0;
      endcase
   end

   // busy while shift steps remain
   assign busy = (shamt != '0);

   always_ff @(posedge clk) begin
      if (!reset) begin
         shamt <= '0;
      end else if (start) begin
         shamt <= in2[`RV_SHAMT_W-1:0];
      end else if (busy) begin
         shamt <= shamt - 1'b1;
      end
   end

   // funct3[2] picks right shifts and bit 30 turns srl into sra
   always_ff @(posedge clk) begin
      if (start) begin
         shiftReg <= in1;
      end else if (busy) begin
         if (decoded.funct3[2]) begin
            shiftReg <= {decoded.altFunct & shiftReg[`RV_XLEN-1],
                         shiftReg[`RV_XLEN-1:1]};
         end else begin
            shiftReg <= {shiftReg[`RV_XLEN-2:0], 1'b0};
         end
      end
   end

endmodule

//--- rtl/rvRegFile.sv
// 32 x 32 register file with two registered read ports and one write port
`timescale 1ns/100ps
`include "rv_defines.svh"

module rvRegFile (
   input  logic                   clk,
   // operands are captured only while the instruction is accepted
   input  logic                   readEn,
   input  logic [`RV_SHAMT_W-1:0] rs1Idx,
   input  logic [`RV_SHAMT_W-1:0] rs2Idx,
   output logic [`RV_XLEN-1:0]    rs1Data,
   output logic [`RV_XLEN-1:0]    rs2Data,
   input  logic                   writeEn,
   input  logic [`RV_SHAMT_W-1:0] rdIdx,
   input  logic [`RV_XLEN-1:0]    rdData
);

   logic [`RV_XLEN-1:0] regs [`RV_NREGS];

   // x0 is never written
   always_ff @(posedge clk) begin
      if (writeEn && (rdIdx != '0)) begin
         regs[rdIdx] <= rdData;
      end
   end

   // read ports hold their value until the next accepted instruction
   // so a write to rd does not disturb a pending load or store address
   always_ff @(posedge clk) begin
      if (readEn) begin
         // entry zero reads as zero whatever the array holds
         rs1Data <= (rs1Idx == '0) ? '0 : regs[rs1Idx];
         rs2Data <= (rs2Idx == '0) ? '0 : regs[rs2Idx];
      end
   end

endmodule

//--- rtl/rvDecoder.sv
// decoder from instruction word to decoded struct with immediates and flags
`timescale 1ns/100ps
`include "rv_defines.svh"

module rvDecoder (
   input  logic [`RV_XLEN-1:0]   instrWord,
   output rv_pkg::decodedInstr_t decoded
);
   import rv_pkg::*;

   opcode_t opcode;

   // unknown or compressed encodings decode as the illegal opcode
   always_comb begin
      if (instrWord[1:0] != 2'b11) begin
         opcode = opIllegal;
      end else begin
         case (instrWord[6:2])
            opLoad, opAluImm, opAuipc, opStore, opAluReg,
            opLui, opBranch, opJalr, opJal: begin
               opcode = opcode_t'(instrWord[6:2]);
            end
            default: begin
               opcode = opIllegal;
            end
         endcase
      end
   end

   always_comb begin
      decoded.opcode     = opcode;
      decoded.rd         = instrWord[11:7];
      decoded.rs1        = instrWord[19:15];
      decoded.rs2        = instrWord[24:20];
      decoded.funct3     = instrWord[14:12];
      decoded.altFunct   = instrWord[30];
      decoded.regOperand = instrWord[5];

      // the five immediate formats are sign extended from bit 31
      decoded.immI = {{(`RV_XLEN-11){instrWord[31]}}, instrWord[30:20]};
      decoded.immS = {{(`RV_XLEN-11){instrWord[31]}}, instrWord[30:25],
                      instrWord[11:7]};
      // B and J carry an implicit zero lsb
      decoded.immB = {{(`RV_XLEN-12){instrWord[31]}}, instrWord[7],
                      instrWord[30:25], instrWord[11:8], 1'b0};
      decoded.immJ = {{(`RV_XLEN-20){instrWord[31]}}, instrWord[19:12],
                      instrWord[20], instrWord[30:21], 1'b0};
      // upper immediate fills the low 12 bits with zeros
      decoded.immU = {instrWord[31:12], 12'b0};

      decoded.isAlu = (opcode == opAluImm) || (opcode == opAluReg);
      // funct3 001 is sll and 101 is srl or sra
      decoded.isShift = decoded.isAlu && (instrWord[13:12] == 2'b01);
      // branches, stores and no-ops leave rd untouched
      decoded.writesRd = !((opcode == opBranch) || (opcode == opStore) ||
                           (opcode == opIllegal));
      // second ALU operand is rs2 for reg ops and compares and immI otherwise
      decoded.usesRs2Operand = (opcode == opAluReg) || (opcode == opBranch);
   end

endmodule

//--- rtl/rv_pkg.sv
// shared types of the RV32I core
// opcode and controller state enums, decoded instruction struct
// and the memory bus request and response structs
`include "rv_defines.svh"

package rv_pkg;

   // kept major opcodes taken from instruction bits 6..2
   typedef enum logic [4:0] {
      opLoad    = 5'b00000,
      opAluImm  = 5'b00100,
      opAuipc   = 5'b00101,
      opStore   = 5'b01000,
      opAluReg  = 5'b01100,
      opLui     = 5'b01101,
      opBranch  = 5'b11000,
      opJalr    = 5'b11001,
      opJal     = 5'b11011,
      // everything else executes as a no-op
      opIllegal = 5'b11111
   } opcode_t;

   // controller states with one instruction in flight at a time
   typedef enum logic [1:0] {
      fetchInstr,
      waitInstr,
      execute,
      waitAluOrMem
   } ctrlState_t;

   // fully decoded instruction
   typedef struct packed {
      opcode_t                opcode;
      logic [4:0]             rd;
      logic [4:0]             rs1;
      logic [4:0]             rs2;
      logic [2:0]             funct3;
      // instr[30] selects sub and arithmetic shift right
      logic                   altFunct;
      // instr[5] is set for the register form of ALU ops
      logic                   regOperand;
      logic [`RV_XLEN-1:0]    immI;
      logic [`RV_XLEN-1:0]    immS;
      logic [`RV_XLEN-1:0]    immB;
      logic [`RV_XLEN-1:0]    immJ;
      logic [`RV_XLEN-1:0]    immU;
      logic                   isAlu;
      logic                   isShift;
      logic                   writesRd;
      logic                   usesRs2Operand;
   } decodedInstr_t;

   // core to memory
   typedef struct packed {
      logic [`RV_XLEN-1:0]    addr;
      logic [`RV_XLEN-1:0]    wdata;
      logic [3:0]             wmask;
      logic                   rstrb;
   } memReq_t;

   // memory to core
   typedef struct packed {
      logic [`RV_XLEN-1:0]    rdata;
      logic                   rbusy;
      logic                   wbusy;
   } memRsp_t;

endpackage

//--- rtl/rv_defines.svh
// core-wide sizing macros for the RV32I multi-cycle core
`ifndef RV_DEFINES_SVH
`define RV_DEFINES_SVH

// data path width, also the width of addresses and registers
`define RV_XLEN 32

// address of the first instruction fetch after reset
// must be word aligned
`define RV_RESET_ADDR 32'h0000_0000

// architectural integer registers, x0 included
`define RV_NREGS 32

// width of a shift amount and of a register index
// log2 of RV_XLEN and of RV_NREGS
`define RV_SHAMT_W 5

`endif
